/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_matrix_mac
FLIST = build.f
OBJ   = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	@out="$$(./$(OBJ)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ)

/* build.f */
mxu_pkg.sv
matrix_seq.sv
mac_lane.sv
result_drain.sv
matrix_mac_top.sv
tb_matrix_mac.sv

/* mac_lane.sv */
`timescale 1ns/1ps

module mac_lane import mxu_pkg::*; (
        input  logic              clk,
        input  logic              rst,
        input  logic [WORD_W-1:0] adc_word,
        input  logic [WORD_W-1:0] coe_word,
        input  logic              beat_valid,
        input  logic              beat_first,
        input  logic              beat_last,
        output logic              lane_valid,
        output logic [ACC_W-1:0]  lane_acc
);

        logic signed [PROD_W-1:0] prod [SAMPLES_PER_WORD];
        logic signed [SUM_W-1:0]  pair_sum [SAMPLES_PER_WORD/2];
        logic signed [SUM_W-1:0]  word_sum;
        logic signed [ACC_W-1:0]  acc;
        logic                     p_valid;
        logic                     p_first;
        logic                     p_last;

        // stage one, elementwise products
        always_ff @(posedge clk) begin
                for (int i = 0; i < SAMPLES_PER_WORD; i++) begin
                        prod[i] <= $signed(adc_word[i*SAMPLE_W +: SAMPLE_W]) *
                                   $signed(coe_word[i*SAMPLE_W +: SAMPLE_W]);
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        p_valid <= 1'b0;
                        p_first <= 1'b0;
                        p_last  <= 1'b0;
                end else begin
                        p_valid <= beat_valid;
                        p_first <= beat_first;
                        p_last  <= beat_last;
                end
        end

        // adder tree
        always_comb begin
                for (int j = 0; j < SAMPLES_PER_WORD/2; j++) begin
                        pair_sum[j] = prod[2*j] + prod[2*j+1];
                end
                word_sum = '0;
                for (int j = 0; j < SAMPLES_PER_WORD/2; j++) begin
                        word_sum = word_sum + pair_sum[j];
                end
        end

        // stage two, load on first beat else accumulate
        always_ff @(posedge clk) begin
                if (p_valid)
                        acc <= p_first ? word_sum : acc + word_sum;
        end

        always_ff @(posedge clk) begin
                if (rst)
                        lane_valid <= 1'b0;
                else
                        lane_valid <= p_valid && p_last;
        end

        assign lane_acc = acc; // held one cycle, next column loads after

endmodule

/* matrix_mac_top.sv */
`timescale 1ns/1ps

module matrix_mac_top import mxu_pkg::*; (
        input  logic                        clk,
        input  logic                        rst,
        input  logic                        trg,
        input  logic [COL_W-1:0]            num_cols,
        input  logic [BEAT_W-1:0]           num_beats,
        input  logic [NUM_LANES*WORD_W-1:0] adc_rdat,
        input  logic [WORD_W-1:0]           coe_rdat,
        input  logic                        res_credit,
        output logic [BEAT_W-1:0]           adc_adr,
        output logic [COE_ADR_W-1:0]        coe_adr,
        output logic                        busy,
        output logic                        res_valid,
        output logic [LANE_W-1:0]           res_lane,
        output logic [ACC_W-1:0]            res_dat
);

        logic                       beat_valid;
        logic                       beat_first;
        logic                       beat_last;
        logic                       slot_free;
        logic [NUM_LANES-1:0]       lane_valid;
        logic [NUM_LANES*ACC_W-1:0] lane_acc;

        matrix_seq i_matrix_seq (
                .clk        (clk),
                .rst        (rst),
                .trg        (trg),
                .num_cols   (num_cols),
                .num_beats  (num_beats),
                .slot_free  (slot_free),
                .adc_adr    (adc_adr),
                .coe_adr    (coe_adr),
                .busy       (busy),
                .beat_valid (beat_valid),
                .beat_first (beat_first),
                .beat_last  (beat_last)
        );

        // coefficient word is common to all lanes
        for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
                mac_lane i_mac_lane (
                        .clk        (clk),
                        .rst        (rst),
                        .adc_word   (adc_rdat[i*WORD_W +: WORD_W]),
                        .coe_word   (coe_rdat),
                        .beat_valid (beat_valid),
                        .beat_first (beat_first),
                        .beat_last  (beat_last),
                        .lane_valid (lane_valid[i]),
                        .lane_acc   (lane_acc[i*ACC_W +: ACC_W])
                );
        end

        result_drain i_result_drain (
                .clk        (clk),
                .rst        (rst),
                .lane_valid (lane_valid),
                .lane_acc   (lane_acc),
                .res_credit (res_credit),
                .res_valid  (res_valid),
                .res_lane   (res_lane),
                .res_dat    (res_dat),
                .slot_free  (slot_free)
        );

endmodule

/* matrix_seq.sv */
`timescale 1ns/1ps

module matrix_seq import mxu_pkg::*; (
        input  logic                 clk,
        input  logic                 rst,
        input  logic                 trg,
        input  logic [COL_W-1:0]     num_cols,  // count minus 1
        input  logic [BEAT_W-1:0]    num_beats, // count minus 1
        input  logic                 slot_free,
        output logic [BEAT_W-1:0]    adc_adr,
        output logic [COE_ADR_W-1:0] coe_adr,
        output logic                 busy,
        output logic                 beat_valid,
        output logic                 beat_first,
        output logic                 beat_last
);

        seq_state_t          state;
        logic [COL_W-1:0]    cols_hld;
        logic [BEAT_W-1:0]   beats_hld;
        logic [COL_W-1:0]    col_cnt;
        logic [BEAT_W-1:0]   beat_cnt;
        logic [SLOT_W-1:0]   slot_cnt;
        logic                slot_ok;
        logic                last_beat;
        logic                last_col;
        logic                issue;
        logic                col_start;

        // a returning slot can be spent in the same cycle
        assign slot_ok   = (slot_cnt != '0) || slot_free;
        assign last_beat = (beat_cnt == beats_hld);
        assign last_col  = (col_cnt == cols_hld);
        assign issue     = (state == ST_RUN);

        always_comb begin
                case (state)
                        ST_IDLE:  col_start = trg && slot_ok;
                        ST_RUN:   col_start = last_beat && !last_col && slot_ok;
                        ST_STALL: col_start = slot_ok;
                        default:  col_start = 1'b0;
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state     <= ST_IDLE;
                        cols_hld  <= '0;
                        beats_hld <= '0;
                        col_cnt   <= '0;
                        beat_cnt  <= '0;
                        slot_cnt  <= SLOT_W'(GROUP_SLOTS);
                end else begin
                        slot_cnt <= slot_cnt + SLOT_W'(slot_free) - SLOT_W'(col_start);
                        case (state)
                                ST_IDLE: begin
                                        if (trg) begin
                                                cols_hld  <= num_cols;
                                                beats_hld <= num_beats;
                                                col_cnt   <= '0;
                                                beat_cnt  <= '0;
                                                state     <= slot_ok ? ST_RUN : ST_STALL;
                                        end
                                end
                                ST_RUN: begin
                                        if (last_beat) begin
                                                beat_cnt <= '0; // sample address restarts
                                                if (last_col) begin
                                                        state <= ST_IDLE;
                                                end else begin
                                                        col_cnt <= col_cnt + 1'b1;
                                                        if (!slot_ok)
                                                                state <= ST_STALL;
                                                end
                                        end else begin
                                                beat_cnt <= beat_cnt + 1'b1;
                                        end
                                end
                                ST_STALL: begin
                                        if (slot_ok)
                                                state <= ST_RUN;
                                end
                                default: state <= ST_IDLE;
                        endcase
                end
        end

        // flags follow the address by one cycle, in step with rdat
        always_ff @(posedge clk) begin
                if (rst) begin
                        beat_valid <= 1'b0;
                        beat_first <= 1'b0;
                        beat_last  <= 1'b0;
                end else begin
                        beat_valid <= issue;
                        beat_first <= issue && (beat_cnt == '0);
                        beat_last  <= issue && last_beat;
                end
        end

        assign adc_adr = beat_cnt;
        assign coe_adr = {col_cnt, beat_cnt};
        assign busy    = (state != ST_IDLE);

endmodule

/* mxu_pkg.sv */
package mxu_pkg;

        // lanes, one sample memory each
        localparam int NUM_LANES = 4;

        // sample and coefficient format
        localparam int SAMPLE_W         = 16;
        localparam int SAMPLES_PER_WORD = 4;
        localparam int WORD_W           = SAMPLE_W * SAMPLES_PER_WORD;

        // full product and one beat's adder tree output
        localparam int PROD_W = 2 * SAMPLE_W;
        localparam int SUM_W  = PROD_W + $clog2(SAMPLES_PER_WORD);

        // accumulator, also the result width
        localparam int ACC_W = 40;

        // job geometry: up to 16 beats per column, up to 64 columns
        localparam int BEAT_W    = 4;
        localparam int COL_W     = 6;
        localparam int COE_ADR_W = COL_W + BEAT_W; // {column, beat}

        localparam int LANE_W = $clog2(NUM_LANES);

        // group buffer in the drain, sequencer holds one credit per slot
        localparam int GROUP_SLOTS = 2;
        localparam int SLOT_W      = $clog2(GROUP_SLOTS + 1);
        localparam int GRP_PTR_W   = $clog2(GROUP_SLOTS);

        // result credits granted by the downstream after reset
        localparam int OUT_CREDITS = 4;
        localparam int CRED_W      = $clog2(OUT_CREDITS + 1);

        // address sequencer
        typedef enum logic [1:0] {
                ST_IDLE  = 2'd0, // waiting for trg
                ST_RUN   = 2'd1, // one beat address per cycle
                ST_STALL = 2'd2  // column boundary, no slot credit
        } seq_state_t;

endpackage

/* result_drain.sv */
`timescale 1ns/1ps

module result_drain import mxu_pkg::*; (
        input  logic                       clk,
        input  logic                       rst,
        input  logic [NUM_LANES-1:0]       lane_valid,
        input  logic [NUM_LANES*ACC_W-1:0] lane_acc,
        input  logic                       res_credit,
        output logic                       res_valid,
        output logic [LANE_W-1:0]          res_lane,
        output logic [ACC_W-1:0]           res_dat,
        output logic                       slot_free
);

        logic [NUM_LANES*ACC_W-1:0] grp_mem [GROUP_SLOTS];
        logic [GRP_PTR_W-1:0]       wr_ptr;
        logic [GRP_PTR_W-1:0]       rd_ptr;
        logic [SLOT_W-1:0]          grp_cnt;
        logic [CRED_W-1:0]          cred_cnt;
        logic [LANE_W-1:0]          lane_idx;
        logic                       grp_wr;
        logic                       send;
        logic                       grp_done;

        assign grp_wr   = &lane_valid; // lanes run in lockstep
        assign send     = (grp_cnt != '0) && (cred_cnt != '0);
        assign grp_done = send && (lane_idx == LANE_W'(NUM_LANES - 1));

        // group ring buffer
        always_ff @(posedge clk) begin
                if (grp_wr)
                        grp_mem[wr_ptr] <= lane_acc;
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        wr_ptr  <= '0;
                        rd_ptr  <= '0;
                        grp_cnt <= '0;
                end else begin
                        grp_cnt <= grp_cnt + SLOT_W'(grp_wr) - SLOT_W'(grp_done);
                        if (grp_wr)
                                wr_ptr <= (wr_ptr == GRP_PTR_W'(GROUP_SLOTS - 1)) ?
                                          '0 : wr_ptr + 1'b1;
                        if (grp_done)
                                rd_ptr <= (rd_ptr == GRP_PTR_W'(GROUP_SLOTS - 1)) ?
                                          '0 : rd_ptr + 1'b1;
                end
        end

        // serializer, lane 0 first
        always_ff @(posedge clk) begin
                if (rst) begin
                        lane_idx  <= '0;
                        cred_cnt  <= CRED_W'(OUT_CREDITS);
                        res_valid <= 1'b0;
                        slot_free <= 1'b0;
                end else begin
                        cred_cnt  <= cred_cnt + CRED_W'(res_credit) - CRED_W'(send);
                        res_valid <= send;
                        slot_free <= grp_done; // back to the sequencer
                        if (send)
                                lane_idx <= grp_done ? '0 : lane_idx + 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (send) begin
                        res_lane <= lane_idx;
                        res_dat  <= grp_mem[rd_ptr][lane_idx*ACC_W +: ACC_W];
                end
        end

endmodule

/* tb_matrix_mac.sv */
`timescale 1ns/1ps

module tb_matrix_mac import mxu_pkg::*; ();

        logic                        clk = 1'b0;
        logic                        rst = 1'b1;
        logic                        trg = 1'b0;
        logic [COL_W-1:0]            num_cols = '0;
        logic [BEAT_W-1:0]           num_beats = '0;
        logic [NUM_LANES*WORD_W-1:0] adc_rdat = '0;
        logic [WORD_W-1:0]           coe_rdat = '0;
        logic                        res_credit = 1'b0;
        logic [BEAT_W-1:0]           adc_adr;
        logic [COE_ADR_W-1:0]        coe_adr;
        logic                        busy;
        logic                        res_valid;
        logic [LANE_W-1:0]           res_lane;
        logic [ACC_W-1:0]            res_dat;

        logic [WORD_W-1:0] adc_mem [NUM_LANES][16];
        logic [WORD_W-1:0] coe_mem [1024];
        logic [ACC_W-1:0]  exp_dat_q [$];
        logic [LANE_W-1:0] exp_lane_q [$];
        logic [ACC_W-1:0]  e_dat;
        logic [LANE_W-1:0] e_lane;

        integer seed = 32'h182d_5a58;
        integer cyc = 0;
        integer n_results = 0;
        integer n_returned = 0;
        integer n_expected = 0;
        integer owed = 0;
        integer gap = 0;
        bit     started = 1'b0;
        bit     withhold = 1'b0;

        matrix_mac_top i_matrix_mac_top (
                .clk        (clk),
                .rst        (rst),
                .trg        (trg),
                .num_cols   (num_cols),
                .num_beats  (num_beats),
                .adc_rdat   (adc_rdat),
                .coe_rdat   (coe_rdat),
                .res_credit (res_credit),
                .adc_adr    (adc_adr),
                .coe_adr    (coe_adr),
                .busy       (busy),
                .res_valid  (res_valid),
                .res_lane   (res_lane),
                .res_dat    (res_dat)
        );

        always #20 clk = ~clk;

        task automatic error_out(input string msg);
                $display("%s", msg);
                $display("TB FAILED");
                $fatal(1, "stopped at first error");
        endtask

        // memories answer one cycle after the address
        always @(posedge clk) begin
                for (int i = 0; i < NUM_LANES; i++)
                        adc_rdat[i*WORD_W +: WORD_W] <= adc_mem[i][adc_adr];
                coe_rdat <= coe_mem[coe_adr];
        end

        // downstream credit return, long holds in withhold mode
        always @(posedge clk) begin
                if (rst) begin
                        res_credit <= 1'b0;
                        owed = 0;
                        gap = 0;
                end else begin
                        res_credit <= 1'b0;
                        if (res_valid === 1'b1)
                                owed = owed + 1;
                        if (gap > 0) begin
                                gap = gap - 1;
                        end else if (owed > 0) begin
                                res_credit <= 1'b1;
                                owed = owed - 1;
                                if (withhold && ({$random(seed)} % 8) == 0)
                                        gap = 20 + {$random(seed)} % 60;
                                else
                                        gap = {$random(seed)} % 7;
                        end
                end
        end

        // output monitor and checker
        always @(posedge clk) begin
                cyc = cyc + 1;
                if (cyc >= 2 && !started)
                        assert (busy === 1'b0 && res_valid === 1'b0) else
                                error_out($sformatf("MISMATCH at %0t: busy %b res_valid %b before trg",
                                          $time, busy, res_valid));
                if (res_credit === 1'b1)
                        n_returned = n_returned + 1;
                if (res_valid === 1'b1) begin
                        n_results = n_results + 1;
                        assert (n_results <= OUT_CREDITS + n_returned) else
                                error_out($sformatf("MISMATCH at %0t: %0d results, %0d credits",
                                          $time, n_results, OUT_CREDITS + n_returned));
                        assert (exp_dat_q.size() != 0) else
                                error_out("a result arrived when none was expected");
                        e_dat = exp_dat_q.pop_front();
                        e_lane = exp_lane_q.pop_front();
                        assert (res_lane === e_lane && res_dat === e_dat) else
                                error_out($sformatf(
                                        "MISMATCH at %0t: lane %0d data %0d, expected lane %0d data %0d",
                                        $time, res_lane, $signed(res_dat), e_lane, $signed(e_dat)));
                end
        end

        function automatic longint samp(input logic [WORD_W-1:0] w, input int s);
                logic signed [SAMPLE_W-1:0] v;
                v = w[s*SAMPLE_W +: SAMPLE_W];
                return longint'(v);
        endfunction

        // mode 0 random, 1 all most negative, 2 all most positive
        task automatic fill_mem(input int mode);
                logic [WORD_W-1:0] w;
                for (int a = 0; a < 1024; a++) begin
                        w = (mode == 1) ? {SAMPLES_PER_WORD{16'h8000}} :
                            (mode == 2) ? {SAMPLES_PER_WORD{16'h7fff}} :
                            {$random(seed), $random(seed)};
                        coe_mem[a] = w;
                        if (a < 16) begin
                                for (int l = 0; l < NUM_LANES; l++)
                                        adc_mem[l][a] = (mode == 0) ?
                                                {$random(seed), $random(seed)} : w;
                        end
                end
        endtask

        // expected results, column order, lane 0 first
        task automatic model_job(input int nc, input int nb);
                longint sum;
                for (int c = 0; c < nc; c++) begin
                        for (int l = 0; l < NUM_LANES; l++) begin
                                sum = 0;
                                for (int b = 0; b < nb; b++)
                                        for (int s = 0; s < SAMPLES_PER_WORD; s++)
                                                sum += samp(adc_mem[l][b], s) *
                                                       samp(coe_mem[c*16 + b], s);
                                exp_dat_q.push_back(sum[ACC_W-1:0]);
                                exp_lane_q.push_back(LANE_W'(l));
                        end
                end
                n_expected = n_expected + nc * NUM_LANES;
        endtask

        task automatic wait_idle();
                int n;
                n = 0;
                do begin
                        @(posedge clk);
                        n++;
                        if (n > 5000)
                                error_out("timeout: busy never fell after the trigger");
                end while (busy !== 1'b0);
        endtask

        task automatic wait_drained();
                int n;
                n = 0;
                while (exp_dat_q.size() != 0) begin
                        @(posedge clk);
                        n++;
                        if (n > 50000)
                                error_out("timeout: not all expected results arrived");
                end
        endtask

        task automatic run_job(input int nc, input int nb, input int mode, input bit retrig);
                fill_mem(mode);
                model_job(nc, nb);
                @(posedge clk);
                started = 1'b1;
                trg       <= 1'b1;
                num_cols  <= COL_W'(nc - 1);
                num_beats <= BEAT_W'(nb - 1);
                @(posedge clk);
                trg <= 1'b0;
                if (retrig) begin
                        @(posedge clk);
                        assert (busy === 1'b1) else
                                error_out($sformatf("MISMATCH at %0t: busy %b at the retrigger",
                                          $time, busy));
                        trg <= 1'b1; // must be ignored
                        @(posedge clk);
                        trg <= 1'b0;
                end
                wait_idle();
                wait_drained();
                repeat (20) @(posedge clk); // room for stray extra results
        endtask

        initial begin
                repeat (8) @(posedge clk);
                rst <= 1'b0;
                repeat (10) @(posedge clk);

                for (int k = 0; k < 3; k++)
                        run_job(1 + {$random(seed)} % 8, 1 + {$random(seed)} % 16, 0, 1'b0);

                withhold = 1'b1;
                for (int k = 0; k < 2; k++)
                        run_job(4 + {$random(seed)} % 12, 1 + {$random(seed)} % 16, 0, 1'b0);
                withhold = 1'b0;

                run_job(6, 8, 0, 1'b1);
                run_job(1 + {$random(seed)} % 8, 1 + {$random(seed)} % 16, 0, 1'b0);

                // edge cases
                run_job(1, 1, 0, 1'b0);
                run_job(64, 16, 0, 1'b0);
                run_job(64, 16, 1, 1'b0);
                run_job(64, 16, 2, 1'b0);

                if (exp_dat_q.size() == 0 && n_results == n_expected) begin
                        $display("TB PASSED");
                        $finish;
                end else begin
                        error_out("result count differs from the expected count at the end");
                end
        end

endmodule
